// File: logic/div_pkg.sv
// ------------------------------
// divider package
// widths, vector types, enums and the structs shared by the divider blocks
// ------------------------------
`default_nettype none

package div_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // operand width
  localparam int unsigned data_width = 32;
  // one shift-subtract step per quotient bit
  localparam int unsigned step_count = 32;
  // wide enough to hold step_count
  localparam int unsigned count_width = 6;

  typedef logic [data_width-1:0]  word_t;
  typedef logic [count_width-1:0] count_t;

  // ------------------------------
  // enums
  // ------------------------------

  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } div_state_e;

  // ------------------------------
  // messages
  // ------------------------------

  // request, fn in the top bit
  typedef struct packed {
    div_fn_e fn;
    word_t   a;
    word_t   b;
  } div_req_t;

  // remainder high, quotient low
  typedef struct packed {
    word_t rem;
    word_t quot;
  } div_resp_t;

  // control to datapath
  typedef struct packed {
    logic load;
    logic step;
  } div_ctrl_t;

endpackage

`default_nettype wire

// File: logic/div_sign_unit.sv
// ------------------------------
// divider sign unit
// operand magnitudes on the way in, sign fix-up on the way out
// ------------------------------
`default_nettype none
`timescale 1ns/1ps

module div_sign_unit (
  input  div_pkg::div_fn_e   fn,
  input  div_pkg::word_t     a,
  input  div_pkg::word_t     b,
  input  div_pkg::word_t     raw_quot,
  input  div_pkg::word_t     raw_rem,
  input  logic               sign_a,
  input  logic               sign_b,
  output div_pkg::word_t     mag_a,
  output div_pkg::word_t     mag_b,
  output logic               sign_a_now,
  output logic               sign_b_now,
  output div_pkg::div_resp_t resp
);

  logic signed_mode;
  logic neg_quot;
  logic neg_rem;

  // ------------------------------
  // operand side
  // ------------------------------

  assign signed_mode = (fn == div_pkg::div_fn_signed);

  // raw top bits, qualified by the stored fn in the datapath
  assign sign_a_now = a[div_pkg::data_width-1];
  assign sign_b_now = b[div_pkg::data_width-1];

  // two's complement magnitude only for negative signed operands
  // most negative value maps onto itself, still correct as unsigned
  assign mag_a = (signed_mode && sign_a_now) ? div_pkg::word_t'(~a + 1'b1) : a;
  assign mag_b = (signed_mode && sign_b_now) ? div_pkg::word_t'(~b + 1'b1) : b;

  // ------------------------------
  // result side
  // ------------------------------

  // quotient negative when the signs differ
  assign neg_quot = sign_a ^ sign_b;
  // remainder follows the dividend
  assign neg_rem  = sign_a;

  assign resp.quot = neg_quot ? div_pkg::word_t'(~raw_quot + 1'b1) : raw_quot;
  assign resp.rem  = neg_rem  ? div_pkg::word_t'(~raw_rem + 1'b1)  : raw_rem;

endmodule

`default_nettype wire

// File: logic/div_dpath.sv
// ------------------------------
// divider datapath
// operand registers and the restoring shift-subtract register
// ------------------------------
`default_nettype none
`timescale 1ns/1ps

module div_dpath (
  input  logic               clk,
  input  logic               reset,
  input  div_pkg::div_req_t  req,
  input  div_pkg::div_ctrl_t ctrl,
  output div_pkg::div_resp_t resp
);

  // ------------------------------
  // declarations
  // ------------------------------

  // captured request state
  div_pkg::div_fn_e fn_q;
  logic             sign_a_q;
  logic             sign_b_q;
  div_pkg::word_t   divisor_q;

  // {remainder, quotient} with one guard bit on top
  logic [2*div_pkg::data_width:0] rq_q;

  // sign unit hookup
  div_pkg::word_t mag_a;
  div_pkg::word_t mag_b;
  logic           sign_a_now;
  logic           sign_b_now;
  logic           signed_q;
  logic           res_sign_a;
  logic           res_sign_b;

  // one iteration
  logic [2*div_pkg::data_width:0] shifted;
  logic [div_pkg::data_width:0]   diff;
  logic                           diff_neg;

  // ------------------------------
  // sign handling
  // ------------------------------

  assign signed_q = (fn_q == div_pkg::div_fn_signed);

  // stored signs only count in signed mode
  assign res_sign_a = sign_a_q && signed_q;
  assign res_sign_b = sign_b_q && signed_q;

  div_sign_unit sign0 (
    .fn         (req.fn),
    .a          (req.a),
    .b          (req.b),
    .raw_quot   (rq_q[div_pkg::data_width-1:0]),
    .raw_rem    (rq_q[2*div_pkg::data_width-1:div_pkg::data_width]),
    .sign_a     (res_sign_a),
    .sign_b     (res_sign_b),
    .mag_a      (mag_a),
    .mag_b      (mag_b),
    .sign_a_now (sign_a_now),
    .sign_b_now (sign_b_now),
    .resp       (resp)
  );

  // ------------------------------
  // shift-subtract step
  // ------------------------------

  always_comb begin
    // shift the whole register left by one
    shifted  = rq_q << 1;
    // trial subtract on the upper 33 bits
    diff     = shifted[2*div_pkg::data_width:div_pkg::data_width] - {1'b0, divisor_q};
    // top bit of the 33-bit difference is the sign
    diff_neg = diff[div_pkg::data_width];
  end

  // ------------------------------
  // registers
  // ------------------------------

  // payload only, moves under load or step and holds otherwise
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      fn_q      <= req.fn;
      sign_a_q  <= sign_a_now;
      sign_b_q  <= sign_b_now;
      divisor_q <= mag_b;
      // dividend magnitude in the low half, upper part cleared
      rq_q      <= {{(div_pkg::data_width+1){1'b0}}, mag_a};
    end else if (ctrl.step) begin
      if (diff_neg) begin
        // restore, shift in a 0
        rq_q <= shifted;
      end else begin
        // keep the difference, shift in a 1
        rq_q <= {diff, shifted[div_pkg::data_width-1:1], 1'b1};
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  // control never asks for a load in the middle of a division
  step_excludes_load: assert property (
    @(posedge clk) disable iff (reset)
    ctrl.step |-> !ctrl.load
  ) else $error("div_dpath: load and step high together");

endmodule

`default_nettype wire

// File: logic/div_ctrl.sv
// ------------------------------
// divider control
// idle/calc/done FSM, step counter and handshakes
// ------------------------------
`default_nettype none
`timescale 1ns/1ps

module div_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_valid,
  output logic               req_ready,
  output logic               resp_valid,
  input  logic               resp_ready,
  output div_pkg::div_ctrl_t ctrl
);

  div_pkg::div_state_e state_q;
  div_pkg::div_state_e state_d;
  div_pkg::count_t     count_q;
  div_pkg::count_t     count_d;
  logic                last_step;

  // ------------------------------
  // next state
  // ------------------------------

  // count is zero on the first step
  assign last_step = (count_q == div_pkg::count_t'(div_pkg::step_count - 1));

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    case (state_q)
      div_pkg::st_idle: begin
        // accept, start counting from zero
        if (req_valid) begin
          state_d = div_pkg::st_calc;
          count_d = '0;
        end
      end
      div_pkg::st_calc: begin
        if (last_step) begin
          state_d = div_pkg::st_done;
        end else begin
          count_d = count_q + 1'b1;
        end
      end
      div_pkg::st_done: begin
        // wait here until the response is taken
        if (resp_ready) begin
          state_d = div_pkg::st_idle;
        end
      end
      default: begin
        state_d = div_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= div_pkg::st_idle;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------

  assign req_ready  = (state_q == div_pkg::st_idle);
  assign resp_valid = (state_q == div_pkg::st_done);

  // load on the accepting edge only
  assign ctrl.load = req_ready && req_valid;
  // one iteration per calc cycle
  assign ctrl.step = (state_q == div_pkg::st_calc);

  // ------------------------------
  // checks
  // ------------------------------

  count_in_range: assert property (
    @(posedge clk) disable iff (reset)
    (state_q == div_pkg::st_calc) |-> (count_q < div_pkg::step_count)
  ) else $error("div_ctrl: step counter past the last step");

  ready_valid_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(req_ready && resp_valid)
  ) else $error("div_ctrl: req_ready and resp_valid high together");

endmodule

`default_nettype wire

// File: logic/int_div_iterative.sv
// ------------------------------
// iterative 32-bit divider
// top level, datapath plus control
// ------------------------------
`default_nettype none
`timescale 1ns/1ps

module int_div_iterative (
  input  logic               clk,
  input  logic               reset,

  // request side
  input  div_pkg::div_req_t  req,
  input  logic               req_valid,
  output logic               req_ready,

  // response side
  output div_pkg::div_resp_t resp,
  output logic               resp_valid,
  input  logic               resp_ready
);

  // enables from control to datapath
  div_pkg::div_ctrl_t ctrl;

  // ------------------------------
  // datapath
  // ------------------------------

  div_dpath dpath0 (
    .clk   (clk),
    .reset (reset),
    .req   (req),
    .ctrl  (ctrl),
    .resp  (resp)
  );

  // ------------------------------
  // control
  // ------------------------------

  div_ctrl ctrl0 (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .ctrl       (ctrl)
  );

endmodule

`default_nettype wire

// File: tb/int_div_tb.sv
// ------------------------------
// iterative divider testbench
// random and directed divides against a reference model
// ------------------------------
`default_nettype none
`timescale 1ns/1ps

module int_div_tb;

  logic               clk;
  logic               reset;
  div_pkg::div_req_t  req;
  logic               req_valid;
  logic               req_ready;
  div_pkg::div_resp_t resp;
  logic               resp_valid;
  logic               resp_ready;

  // scoreboard and bookkeeping
  div_pkg::div_resp_t exp_queue[$];
  div_pkg::div_resp_t exp_head;
  logic               exp_pending;
  logic               in_flight;
  int unsigned        since_accept;
  string              test_name;
  string              active_name;
  logic [31:0]        lfsr_state;
  int unsigned        error_count;
  int unsigned        transfer_count;
  int unsigned        test_count;
  int unsigned        base_errors;
  int unsigned        base_transfers;
  logic               aborted;

  int_div_iterative dut0 (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ------------------------------
  // random source and reference
  // ------------------------------

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int unsigned count);
    logic [31:0] bits;
    logic        fb;
    int unsigned i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // ready one cycle in four under back-pressure
  function automatic logic pick_ready(input logic random_bp);
    logic [31:0] bits;
    if (!random_bp) begin
      return 1'b1;
    end
    bits = take_bits(2);
    return (bits == 32'd3);
  endfunction

  // divide magnitudes, then fix signs
  // b = 0 gives all ones and the dividend magnitude before the fix
  function automatic div_pkg::div_resp_t ref_divide(input div_pkg::div_req_t r);
    div_pkg::word_t     mag_a;
    div_pkg::word_t     mag_b;
    div_pkg::word_t     q;
    div_pkg::word_t     rm;
    logic               neg_a;
    logic               neg_b;
    div_pkg::div_resp_t res;
    neg_a = (r.fn == div_pkg::div_fn_signed) && r.a[31];
    neg_b = (r.fn == div_pkg::div_fn_signed) && r.b[31];
    mag_a = neg_a ? -r.a : r.a;
    mag_b = neg_b ? -r.b : r.b;
    if (mag_b == '0) begin
      q  = '1;
      rm = mag_a;
    end else begin
      q  = mag_a / mag_b;
      rm = mag_a % mag_b;
    end
    if (neg_a != neg_b) begin
      q = -q;
    end
    if (neg_a) begin
      rm = -rm;
    end
    res.quot = q;
    res.rem  = rm;
    return res;
  endfunction

  // ------------------------------
  // monitor
  // ------------------------------

  always @(posedge clk) begin
    if (reset) begin
      exp_queue.delete();
      exp_pending  <= 1'b0;
      in_flight    <= 1'b0;
      since_accept <= 0;
    end else begin
      if (resp_valid && resp_ready) begin
        if (exp_queue.size() != 0) begin
          exp_queue.delete(0);
        end
        transfer_count++;
        in_flight <= 1'b0;
      end
      if (req_valid && req_ready) begin
        exp_queue.push_back(ref_divide(req));
        in_flight    <= 1'b1;
        since_accept <= 1;
        active_name  <= test_name;
      end else if (in_flight && !resp_valid) begin
        // frozen once the response shows up
        since_accept <= since_accept + 1;
      end
      exp_pending <= (exp_queue.size() != 0);
      if (exp_queue.size() != 0) begin
        exp_head <= exp_queue[0];
      end
    end
  end

  // ------------------------------
  // checks
  // ------------------------------

  reset_idle: assert property (@(posedge clk) $fell(reset) |-> (req_ready && !resp_valid))
    else begin
      error_count++;
      $display("divider not idle and ready after reset");
    end

  resp_expected: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready) |-> exp_pending)
    else begin
      error_count++;
      $display("response transferred with no request outstanding");
    end

  result_match: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && resp_ready && exp_pending) |-> (resp == exp_head))
    else begin
      error_count++;
      $display("CHECK FAILED %s expected %h actual %h", active_name, exp_head, resp);
    end

  // back-pressure holds valid and payload
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp)))
    else begin
      error_count++;
      $display("response dropped or changed while resp_ready was low in %s", active_name);
    end

  busy_blocks_req: assert property (@(posedge clk) disable iff (reset)
    in_flight |-> !req_ready)
    else begin
      error_count++;
      $display("req_ready high while a division was in flight in %s", active_name);
    end

  // 32 steps plus the load edge
  latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_valid) |-> (since_accept == div_pkg::step_count + 1))
    else begin
      error_count++;
      $display("CHECK FAILED %s latency expected %0d actual %0d", active_name,
               div_pkg::step_count + 1, since_accept);
    end

  // ------------------------------
  // stimulus tasks
  // ------------------------------

  task automatic start_test(input string name);
    test_name      = name;
    base_errors    = error_count;
    base_transfers = transfer_count;
    test_count++;
  endtask

  task automatic finish_test();
    // let the last checks settle
    repeat (2) @(posedge clk);
    $display("test %s divisions %0d errors %0d", test_name,
             transfer_count - base_transfers, error_count - base_errors);
  endtask

  // one request through both handshakes, 200 cycle limit per wait
  task automatic run_divide(input div_pkg::div_fn_e fn, input div_pkg::word_t a,
                            input div_pkg::word_t b, input logic random_bp);
    int unsigned waited;
    logic        done;
    if (aborted) begin
      return;
    end
    req        <= div_pkg::div_req_t'({fn, a, b});
    req_valid  <= 1'b1;
    resp_ready <= pick_ready(random_bp);
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 200) begin
      @(posedge clk);
      waited++;
      if (req_ready) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      aborted = 1'b1;
      $display("timeout, request not accepted in %s", test_name);
      return;
    end
    req_valid <= 1'b0;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < 200) begin
      resp_ready <= pick_ready(random_bp);
      @(posedge clk);
      waited++;
      if (resp_valid && resp_ready) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      aborted = 1'b1;
      $display("timeout, no response transferred in %s", test_name);
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    div_pkg::word_t   a;
    div_pkg::word_t   b;
    div_pkg::word_t   a_mag;
    div_pkg::word_t   b_mag;
    div_pkg::div_fn_e fn;
    int unsigned      i;
    clk            = 1'b0;
    reset          = 1'b1;
    req            = '0;
    req_valid      = 1'b0;
    resp_ready     = 1'b0;
    lfsr_state     = 32'h4f13;
    error_count    = 0;
    transfer_count = 0;
    test_count     = 0;
    aborted        = 1'b0;
    test_name      = "none";
    active_name    = "none";

    start_test("reset_state");
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    finish_test();

    // a < b, b = 1 and top bits set in turn
    start_test("unsigned");
    for (i = 0; i < 24; i++) begin
      a = take_bits(32);
      b = take_bits(32);
      case (i % 4)
        0: b = (b >> take_bits(5)) | 32'd1;
        1: begin
          a = a >> 16;
          b[31] = 1'b1;
        end
        2: b = 32'd1;
        default: begin
          a[31] = 1'b1;
          b[31] = 1'b1;
        end
      endcase
      run_divide(div_pkg::div_fn_unsigned, a, b, 1'b0);
    end
    finish_test();

    // all four sign pairs, then the overflow corner
    start_test("signed");
    for (i = 0; i < 16; i++) begin
      a_mag = take_bits(31);
      b_mag = (take_bits(31) >> take_bits(4)) | 32'd1;
      a = i[0] ? -a_mag : a_mag;
      b = i[1] ? -b_mag : b_mag;
      run_divide(div_pkg::div_fn_signed, a, b, 1'b0);
    end
    run_divide(div_pkg::div_fn_signed, 32'h8000_0000, 32'hffff_ffff, 1'b0);
    run_divide(div_pkg::div_fn_signed, -32'd7, 32'd2, 1'b0);
    run_divide(div_pkg::div_fn_signed, 32'd7, -32'd2, 1'b0);
    finish_test();

    start_test("divide_zero");
    run_divide(div_pkg::div_fn_unsigned, take_bits(31), '0, 1'b0);
    run_divide(div_pkg::div_fn_unsigned, take_bits(32) | 32'h8000_0000, '0, 1'b0);
    run_divide(div_pkg::div_fn_signed, take_bits(31), '0, 1'b0);
    run_divide(div_pkg::div_fn_signed, take_bits(32) | 32'h8000_0000, '0, 1'b0);
    finish_test();

    // random fn, resp_ready toggling
    start_test("backpressure");
    for (i = 0; i < 16; i++) begin
      fn = (take_bits(1) == 32'd1) ? div_pkg::div_fn_signed : div_pkg::div_fn_unsigned;
      a  = take_bits(32);
      b  = take_bits(32) >> take_bits(5);
      run_divide(fn, a, b, 1'b1);
    end
    finish_test();

    $display("tests %0d divisions %0d errors %0d timeout %0d", test_count,
             transfer_count, error_count, aborted);
    if (error_count == 0 && !aborted) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/div_pkg.sv
logic/div_sign_unit.sv
logic/div_dpath.sv
logic/div_ctrl.sv
logic/int_div_iterative.sv
tb/int_div_tb.sv

// File: run.sh
#!/bin/sh
# build and run the divider testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module int_div_tb -f tb.f; then
  echo "verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/Vint_div_tb 2>&1); then
  printf '%s\n' "$output"
  echo "simulation exited with an error"
  exit 1
fi

printf '%s\n' "$output"

# pass only when the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "Test passed"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1
